// ==== rtl/wbuf_defs.svh ====
// Build-time sizing only; WBUF_DEPTH must be at least 1 and the memory spans every address
`ifndef WBUF_DEFS_SVH
`define WBUF_DEFS_SVH

// Number of entries in the posted-write queue
`define WBUF_DEPTH 4

// Width of a word address on both the processor port and the memory bus
`define WBUF_ADDRESS_WIDTH 8

// 1 makes a read wait for an empty queue, 0 lets a read pass queued writes
`define WBUF_STALL_READ 1

// Extra cycles the memory target waits before raising ready
`define MEM_WAIT_STATES 2

`endif

// ==== rtl/bus_pkg.sv ====
// Memory bus types; data is always one full 32-bit word, no byte enables or bursts
`default_nettype none

`include "wbuf_defs.svh"

package bus_pkg;

	// One data word on the bus
	typedef logic [31:0] word_t;

	// Word address, shared by the processor port and the memory
	typedef logic [`WBUF_ADDRESS_WIDTH-1:0] address_t;

	// Direction of a bus transfer
	typedef enum logic {
		bus_read = 1'b0,
		bus_write = 1'b1
	} bus_op_t;

endpackage

`default_nettype wire

// ==== rtl/wbuf_pkg.sv ====
// Write buffer types; the queue entry is address above data, with no byte enables
`default_nettype none

package wbuf_pkg;

	// Controller states
	typedef enum logic [2:0] {
		idle = 3'd0,
		write_to_queue = 3'd1,
		read_from_bus = 3'd2,
		drain_entry = 3'd3,
		terminate_drain = 3'd4
	} wbuf_state_t;

	// One posted write as it sits in the queue
	typedef struct packed {
		bus_pkg::address_t address;
		bus_pkg::word_t data;
	} queue_entry_t;

endpackage

`default_nettype wire

// ==== rtl/mem_bus_if.sv ====
// Level-handshake memory bus; the initiator holds request and fields until ready is seen
`default_nettype none

interface mem_bus_if;

	logic request;
	bus_pkg::bus_op_t op;
	bus_pkg::address_t address;
	bus_pkg::word_t wdata;
	bus_pkg::word_t rdata;
	logic ready;

	// Write buffer side
	modport initiator (
		output request,
		output op,
		output address,
		output wdata,
		input rdata,
		input ready
	);

	// Memory side
	modport target (
		input request,
		input op,
		input address,
		input wdata,
		output rdata,
		output ready
	);

endinterface

`default_nettype wire

// ==== rtl/write_queue.sv ====
// Queue of posted writes; a write when full and a read when empty are ignored
`default_nettype none

`include "wbuf_defs.svh"

module write_queue (
	input wire i_clock,
	input wire i_reset,
	input wire i_write,
	input wire wbuf_pkg::queue_entry_t i_entry,
	input wire i_read,
	output wbuf_pkg::queue_entry_t o_entry,
	output logic o_empty,
	output logic o_full
);
	localparam int PTR_WIDTH = (`WBUF_DEPTH > 1) ? $clog2(`WBUF_DEPTH) : 1;
	localparam int COUNT_WIDTH = $clog2(`WBUF_DEPTH + 1);
	localparam logic [PTR_WIDTH-1:0] LAST_SLOT = PTR_WIDTH'(`WBUF_DEPTH - 1);
	localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(`WBUF_DEPTH);

	wbuf_pkg::queue_entry_t slots [`WBUF_DEPTH];
	logic [PTR_WIDTH-1:0] write_ptr;
	logic [PTR_WIDTH-1:0] read_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic push;
	logic pop;

	assign o_empty = (count == '0);
	assign o_full = (count == FULL_COUNT);
	assign push = i_write && !o_full;
	assign pop = i_read && !o_empty;

	// Head is visible without a register stage
	assign o_entry = slots[read_ptr];

	always_ff @(posedge i_clock) begin
		if (push) begin
			slots[write_ptr] <= i_entry;
		end
	end

	// Pointers wrap explicitly so any depth works
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			write_ptr <= '0;
			read_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				write_ptr <= (write_ptr == LAST_SLOT) ? '0 : write_ptr + 1'b1;
			end
			if (pop) begin
				read_ptr <= (read_ptr == LAST_SLOT) ? '0 : read_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/write_buffer.sv ====
// Posted-write controller; i_rw high means write, and a read passes queued writes if stall is off
`default_nettype none

`include "wbuf_defs.svh"

module write_buffer (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_rw,
	input wire bus_pkg::address_t i_address,
	input wire bus_pkg::word_t i_wdata,
	output logic o_ready,
	output bus_pkg::word_t o_rdata,
	output logic o_empty,
	output logic o_full,
	mem_bus_if.initiator bus
);
	wbuf_pkg::wbuf_state_t state;
	wbuf_pkg::wbuf_state_t next_state;

	logic queue_write;
	logic queue_read;
	wbuf_pkg::queue_entry_t queue_in;
	wbuf_pkg::queue_entry_t queue_head;
	logic stall_read;

	write_queue write_queue_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_write(queue_write),
		.i_entry(queue_in),
		.i_read(queue_read),
		.o_entry(queue_head),
		.o_empty(o_empty),
		.o_full(o_full)
	);

	assign queue_in = '{address: i_address, data: i_wdata};

	// Reads must not overtake queued writes when stalling is enabled
	assign stall_read = (`WBUF_STALL_READ != 0) && !o_empty;

	// Read data comes straight from the memory register
	assign o_rdata = bus.rdata;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= wbuf_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		queue_write = 1'b0;
		queue_read = 1'b0;
		o_ready = 1'b0;
		bus.request = 1'b0;
		bus.op = bus_pkg::bus_read;
		bus.address = '0;
		bus.wdata = '0;

		case (state)
			wbuf_pkg::idle: begin
				// Processor first, then drain; never both in one cycle
				if (i_request && i_rw && !o_full) begin
					queue_write = 1'b1;
					next_state = wbuf_pkg::write_to_queue;
				end else if (i_request && !i_rw && !stall_read) begin
					next_state = wbuf_pkg::read_from_bus;
				end else if (!o_empty) begin
					next_state = wbuf_pkg::drain_entry;
				end
			end

			wbuf_pkg::write_to_queue: begin
				// Acknowledge until the processor lets go
				o_ready = 1'b1;
				if (!i_request) begin
					next_state = wbuf_pkg::idle;
				end
			end

			wbuf_pkg::read_from_bus: begin
				bus.request = 1'b1;
				bus.op = bus_pkg::bus_read;
				bus.address = i_address;
				o_ready = bus.ready;
				// Bus request stays up until the processor drops its own
				if (!i_request) begin
					next_state = wbuf_pkg::idle;
				end
			end

			wbuf_pkg::drain_entry: begin
				bus.request = 1'b1;
				bus.op = bus_pkg::bus_write;
				bus.address = queue_head.address;
				bus.wdata = queue_head.data;
				// Head leaves the queue only once the memory has taken it
				if (bus.ready) begin
					queue_read = 1'b1;
					next_state = wbuf_pkg::terminate_drain;
				end
			end

			wbuf_pkg::terminate_drain: begin
				// One idle bus cycle so the memory sees request fall
				next_state = wbuf_pkg::idle;
			end

			default: begin
				next_state = wbuf_pkg::idle;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/bus_memory.sv ====
// Bus memory target; contents are undefined until written, and ready needs request to drop between transfers
`default_nettype none

`include "wbuf_defs.svh"

module bus_memory (
	input wire i_clock,
	input wire i_reset,
	mem_bus_if.target bus
);
	localparam int WORDS = 2 ** `WBUF_ADDRESS_WIDTH;
	localparam int WAIT_WIDTH = (`MEM_WAIT_STATES > 0) ? $clog2(`MEM_WAIT_STATES + 1) : 1;
	localparam logic [WAIT_WIDTH-1:0] WAIT_LAST = WAIT_WIDTH'(`MEM_WAIT_STATES);

	bus_pkg::word_t mem [WORDS];
	logic [WAIT_WIDTH-1:0] wait_count;
	logic write_now;

	// Exactly one write per request, on the edge that raises ready
	assign write_now = bus.request && !bus.ready && (wait_count == WAIT_LAST)
		&& (bus.op == bus_pkg::bus_write);

	// Wait-state counter restarts whenever request falls
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wait_count <= '0;
			bus.ready <= 1'b0;
		end else if (!bus.request) begin
			wait_count <= '0;
			bus.ready <= 1'b0;
		end else if (wait_count == WAIT_LAST) begin
			// Ready holds as long as request does
			bus.ready <= 1'b1;
		end else begin
			wait_count <= wait_count + 1'b1;
		end
	end

	always_ff @(posedge i_clock) begin
		if (write_now) begin
			mem[bus.address] <= bus.wdata;
		end
	end

	// Read port tracks the address while a request is up
	always_ff @(posedge i_clock) begin
		if (bus.request) begin
			bus.rdata <= mem[bus.address];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/buffered_memory_top.sv ====
// Top level; processor port follows the level protocol, i_request held until o_ready
`default_nettype none

module buffered_memory_top (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_rw,
	input wire bus_pkg::address_t i_address,
	input wire bus_pkg::word_t i_wdata,
	output logic o_ready,
	output bus_pkg::word_t o_rdata,
	output logic o_empty,
	output logic o_full
);

	// Bus between the buffer and the memory
	mem_bus_if bus_if ();

	write_buffer write_buffer_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_empty(o_empty),
		.o_full(o_full),
		.bus(bus_if.initiator)
	);

	bus_memory bus_memory_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.bus(bus_if.target)
	);

endmodule

`default_nettype wire

// ==== testbench/buffered_memory_props.sv ====
// Protocol checks bound into the top level; reset must be applied from time zero
`default_nettype none

module buffered_memory_props (
	input wire i_clock,
	input wire i_reset,
	input wire i_request,
	input wire i_ready,
	input wire i_empty,
	input wire i_full,
	input wire i_bus_request,
	input wire i_bus_ready
);
	timeunit 1ns;
	timeprecision 100ps;

	// Acknowledge only follows a cycle with the processor request up
	ready_needs_request: assert property (
		@(posedge i_clock) disable iff (i_reset) !i_request |=> !i_ready
	) else $error("o_ready high in the cycle after i_request was low");

	// Queue cannot be empty and full at once
	flags_exclusive: assert property (
		@(posedge i_clock) disable iff (i_reset) !(i_empty && i_full)
	) else $error("o_empty and o_full both high");

	// Bus initiator holds its request until the target answers
	bus_request_held: assert property (
		@(posedge i_clock) disable iff (i_reset) i_bus_request && !i_bus_ready |=> i_bus_request
	) else $error("bus request dropped before ready");

	ready_low_in_reset: assert property (
		@(posedge i_clock) i_reset |-> !i_ready
	) else $error("o_ready high during reset");

endmodule

bind buffered_memory_top buffered_memory_props buffered_memory_props_inst (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_empty(o_empty),
	.i_full(o_full),
	.i_bus_request(bus_if.request),
	.i_bus_ready(bus_if.ready)
);

`default_nettype wire

// ==== testbench/buffered_memory_tb.sv ====
// Assumes the stall-read build; every read targets an address that was written earlier
`default_nettype none

`include "wbuf_defs.svh"

module buffered_memory_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int MAX_ROWS = 64;
	localparam int MEM_WORDS = 2 ** `WBUF_ADDRESS_WIDTH;

	logic clock;
	logic reset;
	logic request;
	logic rw;
	bus_pkg::address_t address;
	bus_pkg::word_t wdata;
	logic ready;
	bus_pkg::word_t rdata;
	logic empty;
	logic full;

	// One stimulus row per processor access
	bus_pkg::bus_op_t row_op [MAX_ROWS];
	bus_pkg::address_t row_address [MAX_ROWS];
	bus_pkg::word_t row_wdata [MAX_ROWS];
	bus_pkg::word_t row_expect [MAX_ROWS];
	int row_count;

	bus_pkg::word_t model_mem [MEM_WORDS];
	bit planned [MEM_WORDS];
	logic seen_full;
	logic timed_out;
	int errors;
	int tests;
	int failed_tests;
	logic [31:0] rng;

	buffered_memory_top buffered_memory_top_inst (
		.i_clock(clock),
		.i_reset(reset),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_ready(ready),
		.o_rdata(rdata),
		.o_empty(empty),
		.o_full(full)
	);

	always #2 clock = ~clock;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic add_row(input bus_pkg::bus_op_t op, input bus_pkg::address_t addr,
			input bus_pkg::word_t data);
		row_op[row_count] = op;
		row_address[row_count] = addr;
		row_wdata[row_count] = data;
		row_expect[row_count] = '0;
		row_count++;
	endtask

	task automatic check_word(input string name, input bus_pkg::word_t got,
			input bus_pkg::word_t expected);
		if (got !== expected) begin
			$display("ERR %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		if (got !== expected) begin
			$display("ERR %s got %h expected %h", name, got, expected);
			errors++;
		end
	endtask

	task automatic finish_run();
		$display("tests %0d, failed tests %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	task automatic report_test(input string name, input int errors_before);
		tests++;
		if (errors == errors_before) begin
			$display("test %0d %s: ok", tests, name);
		end else begin
			failed_tests++;
			$display("test %0d %s: %0d errors", tests, name, errors - errors_before);
		end
	endtask

	// Hold the request until o_ready, then drop it and wait for o_ready to fall
	task automatic apply_row(input int i);
		int cycles;
		bus_pkg::word_t got;
		if (timed_out) begin
			return;
		end
		request = 1'b1;
		rw = (row_op[i] == bus_pkg::bus_write);
		address = row_address[i];
		wdata = row_wdata[i];
		cycles = 0;
		while (!ready && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (!ready) begin
			$display("Timeout: row %0d was never acknowledged", i);
			errors++;
			timed_out = 1'b1;
			request = 1'b0;
			return;
		end
		got = rdata;
		seen_full = full;
		request = 1'b0;
		if (row_op[i] == bus_pkg::bus_write) begin
			model_mem[row_address[i]] = row_wdata[i];
		end else begin
			// Expected value follows every write acknowledged so far
			row_expect[i] = model_mem[row_address[i]];
			check_word("o_rdata", got, row_expect[i]);
		end
		cycles = 0;
		while (ready && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (ready) begin
			$display("Timeout: o_ready stayed high after row %0d", i);
			errors++;
			timed_out = 1'b1;
		end
	endtask

	task automatic apply_rows(input int first, input int last);
		for (int i = first; i <= last; i++) begin
			apply_row(i);
		end
	endtask

	task automatic wait_empty();
		int cycles;
		if (timed_out) begin
			return;
		end
		cycles = 0;
		while (!empty && cycles < TIMEOUT_CYCLES) begin
			@(negedge clock);
			cycles++;
		end
		if (!empty) begin
			$display("Timeout: queue never drained");
			errors++;
			timed_out = 1'b1;
		end
	endtask

	initial begin
		int errors_before;
		int t2_first;
		int t3_first;
		int t3_extra;
		int t3_reads;
		int t4_first;
		int t5_first;
		bus_pkg::address_t addr;
		clock = 1'b0;
		reset = 1'b1;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		row_count = 0;
		seen_full = 1'b0;
		timed_out = 1'b0;
		rng = 32'd13;

		t2_first = row_count;
		add_row(bus_pkg::bus_write, 8'h05, 32'hcafe_0001);
		add_row(bus_pkg::bus_read, 8'h05, '0);

		// Fill the queue, then one write that has to wait for a drain
		t3_first = row_count;
		for (int k = 0; k < `WBUF_DEPTH; k++) begin
			add_row(bus_pkg::bus_write, bus_pkg::address_t'(8'h10 + k), 32'ha000_0000 + 32'(k));
		end
		t3_extra = row_count;
		add_row(bus_pkg::bus_write, bus_pkg::address_t'(8'h10 + `WBUF_DEPTH), 32'hb000_00ff);
		t3_reads = row_count;
		for (int k = 0; k <= `WBUF_DEPTH; k++) begin
			add_row(bus_pkg::bus_read, bus_pkg::address_t'(8'h10 + k), '0);
		end

		t4_first = row_count;
		add_row(bus_pkg::bus_write, 8'h20, 32'h5a5a_0f0f);
		add_row(bus_pkg::bus_read, 8'h20, '0);

		// Random mix; an address is written before it is ever read
		t5_first = row_count;
		for (int k = 0; k < 20; k++) begin
			rng = lcg_next(rng);
			addr = bus_pkg::address_t'({5'b00110, rng[18:16]});
			if (rng[24] || !planned[addr]) begin
				planned[addr] = 1'b1;
				rng = lcg_next(rng);
				add_row(bus_pkg::bus_write, addr, rng);
			end else begin
				add_row(bus_pkg::bus_read, addr, '0);
			end
		end

		repeat (16) @(negedge clock);
		reset = 1'b0;
		@(negedge clock);

		errors_before = errors;
		check_flag("o_empty", empty, 1'b1);
		check_flag("o_full", full, 1'b0);
		check_flag("o_ready", ready, 1'b0);
		report_test("reset state", errors_before);

		errors_before = errors;
		apply_rows(t2_first, t3_first - 1);
		report_test("single write and read", errors_before);

		errors_before = errors;
		apply_rows(t3_first, t3_extra - 1);
		check_flag("o_full", seen_full, 1'b1);
		apply_rows(t3_extra, t3_extra);
		wait_empty();
		check_flag("o_full", full, 1'b0);
		apply_rows(t3_reads, t4_first - 1);
		report_test("full queue and back-pressure", errors_before);

		errors_before = errors;
		apply_rows(t4_first, t5_first - 1);
		report_test("read stalls behind write", errors_before);

		errors_before = errors;
		apply_rows(t5_first, row_count - 1);
		report_test("random accesses", errors_before);

		finish_run();
	end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+rtl
rtl/bus_pkg.sv
rtl/wbuf_pkg.sv
rtl/mem_bus_if.sv
rtl/write_queue.sv
rtl/write_buffer.sv
rtl/bus_memory.sv
rtl/buffered_memory_top.sv
testbench/buffered_memory_props.sv
testbench/buffered_memory_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f all.f \
	--top-module buffered_memory_tb -Mdir obj_dir

output=$(./obj_dir/Vbuffered_memory_tb 2>&1) || true
echo "$output"

if echo "$output" | grep -q "^=== PASS ===$"; then
	exit 0
fi
exit 1
